// ==== Bender.yml ====
package:
  name: ldpc_encoder

export_include_dirs:
  - source

sources:
  - files:
      - source/ldpc_code_pkg.sv
      - source/ldpc_ctrl_pkg.sv
      - source/ldpc_block_seq.sv
      - source/ldpc_circ_accum.sv
      - source/ldpc_parity_join.sv
      - source/ldpc_encoder.sv
  - target: test
    include_dirs:
      - source
      - test
    files:
      - test/ldpc_encoder_tb.sv

// ==== source/ldpc_block_seq.sv ====
`timescale 1ns/1ps

module ldpc_block_seq (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    start,
	input  ldpc_code_pkg::data_t    data,
	input  logic                    done,
	output ldpc_code_pkg::block_t   blk,
	output ldpc_code_pkg::blk_idx_t blk_idx,
	output logic                    blk_valid,
	output logic                    blk_first,
	output logic                    acc_last
);

	localparam int Z  = ldpc_code_pkg::Z;
	localparam int NB = ldpc_code_pkg::NB;

	ldpc_ctrl_pkg::seq_state_t state;
	ldpc_code_pkg::data_t      data_q;
	ldpc_code_pkg::blk_idx_t   cnt;
	logic                      wrap_q;
	logic                      accept;
	logic                      at_last;

	// wrap_q covers the edge where the join still has to latch the result
	assign accept  = (state == ldpc_ctrl_pkg::IDLE) && start && !done && !wrap_q;
	assign at_last = (cnt == ldpc_code_pkg::blk_idx_t'(NB - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= ldpc_ctrl_pkg::IDLE;
			cnt    <= '0;
			wrap_q <= 1'b0;
		end else begin
			wrap_q <= 1'b0;
			case (state)
				ldpc_ctrl_pkg::IDLE: begin
					if (accept) begin
						state <= ldpc_ctrl_pkg::RUN;
						cnt   <= '0;
					end
				end
				ldpc_ctrl_pkg::RUN: begin
					cnt <= cnt + 1'b1;
					if (at_last) begin
						state  <= ldpc_ctrl_pkg::IDLE;
						wrap_q <= 1'b1;
					end
				end
				default: state <= ldpc_ctrl_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			data_q <= data;
		end
	end

	////////////////////////////////////////
	// block presented to the accumulators
	////////////////////////////////////////

	// most significant slice goes first
	assign blk       = data_q[Z*(NB - 1 - int'(cnt)) +: Z];
	assign blk_idx   = cnt;
	assign blk_valid = (state == ldpc_ctrl_pkg::RUN);
	assign blk_first = blk_valid && (cnt == '0);
	assign acc_last  = blk_valid && at_last;

endmodule

// ==== source/ldpc_circ_accum.sv ====
`timescale 1ns/1ps

module ldpc_circ_accum #(
	parameter type shift_set_t = ldpc_code_pkg::shift_one_t,
	parameter shift_set_t SHIFTS [ldpc_code_pkg::NB] = '{default: '0}
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  ldpc_code_pkg::block_t   blk,
	input  ldpc_code_pkg::blk_idx_t blk_idx,
	input  logic                    blk_valid,
	input  logic                    blk_first,
	output ldpc_code_pkg::block_t   acc
);

	localparam int Z  = ldpc_code_pkg::Z;
	localparam int SW = ldpc_code_pkg::SW;
	// circulants per block in this row
	localparam int NS = $bits(shift_set_t) / SW;

	logic [$bits(shift_set_t)-1:0] entry;
	ldpc_code_pkg::block_t         contrib;

	// bit i takes data bit (g+i+1) mod Z
	function automatic ldpc_code_pkg::block_t rotate(
		input ldpc_code_pkg::block_t b,
		input ldpc_code_pkg::shift_t g
	);
		logic [2*Z-1:0] dbl;
		int             r;
		dbl = {b, b};
		r   = (int'(g) + 1) % Z;
		return dbl[r +: Z];
	endfunction

	always_comb begin
		ldpc_code_pkg::shift_t g;
		entry   = SHIFTS[blk_idx];
		contrib = '0;
		for (int k = 0; k < NS; k++) begin
			g = entry[k*SW +: SW];
			// empty circulant adds nothing
			if (g != '0) begin
				contrib = contrib ^ rotate(blk, g);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc <= '0;
		end else if (blk_valid) begin
			acc <= blk_first ? contrib : (acc ^ contrib);
		end
	end

endmodule

// ==== source/ldpc_code_pkg.sv ====
`include "ldpc_settings.svh"

package ldpc_code_pkg;

	localparam int Z  = `LDPC_Z;
	localparam int NB = `LDPC_NB;
	localparam int SW = $clog2(Z);
	localparam int IW = $clog2(NB);

	typedef logic [Z-1:0]      block_t;
	// block 0 sits in the top slice
	typedef logic [NB*Z-1:0]   data_t;
	// row one parity on top, row two below
	typedef logic [2*Z-1:0]    parity_t;
	typedef logic [SW-1:0]     shift_t;
	typedef logic [IW-1:0]     blk_idx_t;

	typedef shift_t [1:0]      shift_pair_t;
	typedef shift_t [0:0]      shift_one_t;

	////////////////////////////////////////
	// shift tables, one entry per block
	// 0 is an empty circulant, Z-1 the identity
	////////////////////////////////////////

	localparam shift_pair_t ROW1_SHIFTS [NB] = '{
		'{13, 41},
		'{0, 27},
		'{63, 5},
		'{38, 0},
		'{22, 57},
		'{9, 63},
		'{0, 0},
		'{50, 31}
	};

	localparam shift_one_t ROW2_SHIFTS [NB] = '{
		'{7},
		'{63},
		'{0},
		'{44},
		'{18},
		'{0},
		'{63},
		'{29}
	};

endpackage

// ==== source/ldpc_ctrl_pkg.sv ====
package ldpc_ctrl_pkg;

	// block sequencer
	typedef enum logic {
		IDLE,
		RUN
	} seq_state_t;

endpackage

// ==== source/ldpc_encoder.sv ====
`timescale 1ns/1ps

module ldpc_encoder (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  ldpc_code_pkg::data_t   data,
	input  logic                   ack,
	output logic                   done,
	output ldpc_code_pkg::parity_t parity
);

	ldpc_code_pkg::block_t   blk;
	ldpc_code_pkg::blk_idx_t blk_idx;
	logic                    blk_valid;
	logic                    blk_first;
	logic                    acc_last;
	ldpc_code_pkg::block_t   acc_row1;
	ldpc_code_pkg::block_t   acc_row2;

	ldpc_block_seq i_seq (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.data      (data),
		.done      (done),
		.blk       (blk),
		.blk_idx   (blk_idx),
		.blk_valid (blk_valid),
		.blk_first (blk_first),
		.acc_last  (acc_last)
	);

	// row one, two circulants per block
	ldpc_circ_accum #(
		.shift_set_t (ldpc_code_pkg::shift_pair_t),
		.SHIFTS      (ldpc_code_pkg::ROW1_SHIFTS)
	) i_row1 (
		.clk       (clk),
		.rst_n     (rst_n),
		.blk       (blk),
		.blk_idx   (blk_idx),
		.blk_valid (blk_valid),
		.blk_first (blk_first),
		.acc       (acc_row1)
	);

	// row two, one circulant per block
	ldpc_circ_accum #(
		.shift_set_t (ldpc_code_pkg::shift_one_t),
		.SHIFTS      (ldpc_code_pkg::ROW2_SHIFTS)
	) i_row2 (
		.clk       (clk),
		.rst_n     (rst_n),
		.blk       (blk),
		.blk_idx   (blk_idx),
		.blk_valid (blk_valid),
		.blk_first (blk_first),
		.acc       (acc_row2)
	);

	ldpc_parity_join i_join (
		.clk      (clk),
		.rst_n    (rst_n),
		.acc_last (acc_last),
		.row1     (acc_row1),
		.row2     (acc_row2),
		.ack      (ack),
		.done     (done),
		.parity   (parity)
	);

endmodule

// ==== source/ldpc_parity_join.sv ====
`timescale 1ns/1ps

module ldpc_parity_join (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   acc_last,
	input  ldpc_code_pkg::block_t  row1,
	input  ldpc_code_pkg::block_t  row2,
	input  logic                   ack,
	output logic                   done,
	output ldpc_code_pkg::parity_t parity
);

	// accumulators settle one edge after acc_last
	logic last_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_q <= 1'b0;
		end else begin
			last_q <= acc_last;
		end
	end

	////////////////////////////////////////
	// result register and done/ack
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done   <= 1'b0;
			parity <= '0;
		end else begin
			if (done && ack) begin
				done <= 1'b0;
			end
			if (last_q) begin
				parity <= {row1, row2};
				done   <= 1'b1;
			end
		end
	end

endmodule

// ==== source/ldpc_settings.svh ====
`ifndef LDPC_SETTINGS_SVH
`define LDPC_SETTINGS_SVH

// circulant size in bits, a power of two
`define LDPC_Z 64

// data blocks per word
`define LDPC_NB 8

`endif

// ==== test/ldpc_tb_model.svh ====
`ifndef LDPC_TB_MODEL_SVH
`define LDPC_TB_MODEL_SVH

////////////////////////////////////////
// reference encoder
////////////////////////////////////////

// bit i of the result is bit (g+i+1) mod Z of b
function automatic ldpc_code_pkg::block_t rotate_block(
	input ldpc_code_pkg::block_t b,
	input int                    g
);
	ldpc_code_pkg::block_t r;
	r = '0;
	// shift 0 is the empty circulant
	if (g != 0) begin
		for (int i = 0; i < ldpc_code_pkg::Z; i++) begin
			r[i] = b[(g + i + 1) % ldpc_code_pkg::Z];
		end
	end
	return r;
endfunction

// block 0 is the top slice of the word
function automatic ldpc_code_pkg::parity_t encode_word(input ldpc_code_pkg::data_t d);
	ldpc_code_pkg::block_t b;
	ldpc_code_pkg::block_t row1;
	ldpc_code_pkg::block_t row2;
	row1 = '0;
	row2 = '0;
	for (int k = 0; k < ldpc_code_pkg::NB; k++) begin
		b    = d[ldpc_code_pkg::Z * (ldpc_code_pkg::NB - 1 - k) +: ldpc_code_pkg::Z];
		row1 = row1 ^ rotate_block(b, int'(ldpc_code_pkg::ROW1_SHIFTS[k][0]));
		row1 = row1 ^ rotate_block(b, int'(ldpc_code_pkg::ROW1_SHIFTS[k][1]));
		row2 = row2 ^ rotate_block(b, int'(ldpc_code_pkg::ROW2_SHIFTS[k][0]));
	end
	return {row1, row2};
endfunction

`endif

// ==== test/ldpc_encoder_tb.sv ====
`timescale 1ns/1ps
`include "ldpc_settings.svh"

module ldpc_encoder_tb;

	localparam int Z          = `LDPC_Z;
	localparam int NB         = `LDPC_NB;
	localparam int WAIT_LIMIT = 4 * NB + 20;

	logic                   clk;
	logic                   rst_n;
	logic                   start;
	logic                   ack;
	logic                   done;
	ldpc_code_pkg::data_t   data;
	ldpc_code_pkg::parity_t parity;

	// what the handshake rules predict
	logic                   pending;
	logic                   any_start;
	int                     lat;
	ldpc_code_pkg::parity_t exp_parity;

	`include "ldpc_tb_model.svh"

	ldpc_encoder i_dut (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (start),
		.data   (data),
		.ack    (ack),
		.done   (done),
		.parity (parity)
	);

	always #2 clk = ~clk;

	task automatic halt_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "stopped at first error");
	endtask

	function automatic ldpc_code_pkg::data_t random_word();
		ldpc_code_pkg::data_t w;
		for (int i = 0; i < $bits(w) / 32; i++) begin
			w[i*32 +: 32] = $urandom;
		end
		return w;
	endfunction

	// start accepted only when no result is pending and done is low
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending    <= 1'b0;
			any_start  <= 1'b0;
			lat        <= 0;
			exp_parity <= '0;
		end else if (!pending && start && !done) begin
			pending    <= 1'b1;
			any_start  <= 1'b1;
			lat        <= 0;
			exp_parity <= encode_word(data);
		end else if (pending) begin
			lat <= lat + 1;
			if (done) begin
				pending <= 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	a_reset_done: assert property (@(posedge clk) disable iff (!rst_n) !any_start |-> !done)
		else halt_run($sformatf("FAIL done: got %h expected %h", $sampled(done), 1'b0));
	a_reset_parity: assert property (@(posedge clk) disable iff (!rst_n)
		!any_start |-> parity == '0)
		else halt_run($sformatf("FAIL parity: got %h expected %h", $sampled(parity), 0));
	a_no_extra: assert property (@(posedge clk) disable iff (!rst_n) $rose(done) |-> pending)
		else halt_run("done rose although no start was accepted");
	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(done) |-> lat == NB + 1)
		else halt_run($sformatf("FAIL done latency: got %h expected %h", $sampled(lat), NB + 1));
	a_parity: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(done) |-> parity == exp_parity)
		else halt_run($sformatf("FAIL parity: got %h expected %h",
			$sampled(parity), $sampled(exp_parity)));
	a_hold_done: assert property (@(posedge clk) disable iff (!rst_n) done && !ack |=> done)
		else halt_run($sformatf("FAIL done: got %h expected %h", $sampled(done), 1'b1));
	a_hold_parity: assert property (@(posedge clk) disable iff (!rst_n)
		done && !ack |=> parity == exp_parity)
		else halt_run($sformatf("FAIL parity: got %h expected %h",
			$sampled(parity), $sampled(exp_parity)));
	a_release: assert property (@(posedge clk) disable iff (!rst_n) done && ack |=> !done)
		else halt_run($sformatf("FAIL done: got %h expected %h", $sampled(done), 1'b0));

	// one full transfer starting at a falling edge
	task automatic encode_and_collect(
		input ldpc_code_pkg::data_t word,
		input int                   hold,
		input bit                   stray
	);
		int n;
		data  = word;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		n = 0;
		while (!done && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!done) begin
			halt_run("timeout: done did not rise after start");
		end
		// ack stall with an optional stray start
		for (int c = 0; c < hold; c++) begin
			start = stray && (c == hold / 2);
			if (start) begin
				data = random_word();
			end
			@(negedge clk);
		end
		start = 1'b0;
		ack   = 1'b1;
		@(negedge clk);
		ack = 1'b0;
	endtask

	initial begin
		ldpc_code_pkg::data_t word;
		void'($urandom(32'h0790_527b));
		clk   = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		ack   = 1'b0;
		data  = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		repeat (3 + $urandom % 8) @(negedge clk);

		// back to back random words
		for (int n = 0; n < 8; n++) begin
			encode_and_collect(random_word(), $urandom % 4, 1'b0);
		end

		// one set bit in each block in turn
		for (int b = 0; b < NB; b++) begin
			word = '0;
			word[Z * (NB - 1 - b) + ($urandom % Z)] = 1'b1;
			encode_and_collect(word, 0, 1'b0);
		end

		// long ack stall and a gap where no second result may appear
		for (int n = 0; n < 4; n++) begin
			encode_and_collect(random_word(), 4 + $urandom % 24, 1'b1);
			repeat (NB + 4) @(negedge clk);
		end

		$display("** PASS **");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+source
+incdir+test
source/ldpc_code_pkg.sv
source/ldpc_ctrl_pkg.sv
source/ldpc_block_seq.sv
source/ldpc_circ_accum.sv
source/ldpc_parity_join.sv
source/ldpc_encoder.sv
test/ldpc_encoder_tb.sv
